//--- fetch_frontend.f
rtl/fetch_pkg.sv
rtl/fetch_word_if.sv
rtl/fetch_request_gen.sv
rtl/prefetch_queue.sv
rtl/instr_assembler.sv
rtl/fetch_frontend.sv
testbench/fetch_bus_model.sv
testbench/tb_fetch_frontend.sv

//--- rtl/fetch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend #(
	parameter fetch_pkg::addr_t RESET_VECTOR = '0,
	parameter int               QUEUE_DEPTH  = 2
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    mem_addr_rdy,
	input  wire fetch_pkg::word_t  mem_data,
	input  wire                    mem_data_err,
	input  wire                    mem_data_vld,
	input  wire fetch_pkg::addr_t  jump_target,
	input  wire                    jump_target_vld,
	input  wire fetch_pkg::level_t cir_use,
	output fetch_pkg::addr_t       mem_addr,
	output logic                   mem_addr_vld,
	output logic                   jump_target_rdy,
	output fetch_pkg::word_t       cir,
	output fetch_pkg::level_t      cir_vld,
	output fetch_pkg::hw_mask_t    cir_err
);
	import fetch_pkg::*;

	// Control between the request generator and the queue
	logic     full;
	logic     almost_full;
	logic     jump_now;
	logic     discard;
	hw_mask_t resp_hwvld;

	// Next fetch word from the queue to the assembler
	fetch_word_if fetch_word ();

	fetch_request_gen #(
		.RESET_VECTOR (RESET_VECTOR)
	) fetch_request_gen_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data_vld    (mem_data_vld),
		.full            (full),
		.almost_full     (almost_full),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.jump_target_rdy (jump_target_rdy),
		.jump_now        (jump_now),
		.discard         (discard),
		.resp_hwvld      (resp_hwvld)
	);

	prefetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) prefetch_queue_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_data     (mem_data),
		.mem_data_err (mem_data_err),
		.mem_data_vld (mem_data_vld),
		.jump_now     (jump_now),
		.discard      (discard),
		.resp_hwvld   (resp_hwvld),
		.full         (full),
		.almost_full  (almost_full),
		.fw           (fetch_word.queue)
	);

	instr_assembler instr_assembler_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.jump_now (jump_now),
		.cir_use  (cir_use),
		.cir      (cir),
		.cir_vld  (cir_vld),
		.cir_err  (cir_err),
		.fw       (fetch_word.assembler)
	);

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// Bus and instruction widths
	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;
	localparam int W_HW   = 16;

	// A fetch or jump address, one full word wide
	typedef logic [W_ADDR-1:0] addr_t;

	// One bus data word, which holds two instruction halfwords
	typedef logic [W_DATA-1:0] word_t;

	// One instruction halfword
	typedef logic [W_HW-1:0] hw_t;

	// One flag per halfword of a word, bit 0 is the lower halfword
	typedef logic [W_DATA/W_HW-1:0] hw_mask_t;

	// Halfword count from 0 to 3
	typedef logic [1:0] level_t;

endpackage

`default_nettype wire

//--- rtl/fetch_request_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_request_gen #(
	parameter fetch_pkg::addr_t RESET_VECTOR = '0
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire fetch_pkg::addr_t    jump_target,
	input  wire                      jump_target_vld,
	input  wire                      mem_addr_rdy,
	input  wire                      mem_data_vld,
	input  wire                      full,
	input  wire                      almost_full,
	output fetch_pkg::addr_t         mem_addr,
	output logic                     mem_addr_vld,
	output logic                     jump_target_rdy,
	output logic                     jump_now,
	output logic                     discard,
	output fetch_pkg::hw_mask_t      resp_hwvld
);
	import fetch_pkg::*;

	// Word address of the next fetch, runs ahead of decode
	addr_t      fetch_addr;
	addr_t      jump_word;
	// Address phase was offered last cycle and not accepted
	logic       mem_addr_hold;
	logic [1:0] pending;
	logic [1:0] flush_pending;
	// Halfword mask of the word in its address phase
	hw_mask_t   aph_hwvld;
	logic       fetch_stall;
	logic       issue;
	logic       accept;

	// ------------------------------------------------------------
	// Address phase

	assign jump_word = {jump_target[W_ADDR-1:2], 2'b00};

	// A held address phase may not change, so jumps wait for it
	assign jump_target_rdy = !mem_addr_hold;
	assign jump_now = jump_target_vld && jump_target_rdy;

	// Registered counts only, so mem_addr_rdy has no path to mem_addr_vld
	// Two queue entries are then needed for full throughput
	assign fetch_stall = full || (almost_full && |pending) || pending > 2'd1;

	always_comb begin
		mem_addr = fetch_addr;
		mem_addr_vld = 1'b1;
		if (mem_addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			// Jump goes out on the bus in the same cycle
			mem_addr = jump_word;
		end else if (fetch_stall) begin
			mem_addr_vld = 1'b0;
		end
	end

	// New request this cycle, as opposed to one being held
	assign issue = mem_addr_vld && !mem_addr_hold;
	assign accept = mem_addr_vld && mem_addr_rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= {RESET_VECTOR[W_ADDR-1:2], 2'b00};
		end else if (jump_now) begin
			// Skip ahead one word if the jump address went straight through
			fetch_addr <= {jump_target[W_ADDR-1:2] + {{(W_ADDR-3){1'b0}}, mem_addr_rdy}, 2'b00};
		end else if (accept) begin
			fetch_addr <= fetch_addr + addr_t'(4);
		end
	end

	// ------------------------------------------------------------
	// Bus pipeline tracking

	// Flushed fetches still return data, which the queue drops
	assign discard = |flush_pending;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_addr_hold <= 1'b0;
			pending <= 2'd0;
			flush_pending <= 2'd0;
		end else begin
			mem_addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending <= pending + {1'b0, issue} - {1'b0, mem_data_vld};
			if (jump_now) begin
				// Everything in flight that does not return this cycle is stale
				flush_pending <= pending - {1'b0, mem_data_vld};
			end else if (discard && mem_data_vld) begin
				flush_pending <= flush_pending - 2'd1;
			end
		end
	end

	// ------------------------------------------------------------
	// Halfword validity

	// A jump to an odd halfword leaves the lower half of its first word unused
	// The mask follows the request from address phase into data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_hwvld <= 2'b11;
			aph_hwvld <= {1'b1, !RESET_VECTOR[1]};
		end else if (jump_now) begin
			if (mem_addr_rdy) begin
				// Jump word is already in its data phase next cycle
				aph_hwvld <= 2'b11;
				resp_hwvld <= {1'b1, !jump_target[1]};
			end else begin
				aph_hwvld <= {1'b1, !jump_target[1]};
			end
		end else if (accept) begin
			resp_hwvld <= aph_hwvld;
			aph_hwvld <= 2'b11;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fetch_word_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fetch_word_if;
	import fetch_pkg::*;

	// Next fetch word, either the queue head or the live bus word
	word_t    data;
	// Halfwords of that word which are real instructions
	hw_mask_t hwvld;
	// Bus error that came back with the word
	logic     err;
	logic     vld;
	// Assembler can take the word this cycle, vld and room together mean taken
	logic     room;

	modport queue (output data, output hwvld, output err, output vld, input room);

	modport assembler (input data, input hwvld, input err, input vld, output room);

endinterface

`default_nettype wire

//--- rtl/instr_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module instr_assembler (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   jump_now,
	input  wire fetch_pkg::level_t cir_use,
	output fetch_pkg::word_t      cir,
	output fetch_pkg::level_t     cir_vld,
	output fetch_pkg::hw_mask_t   cir_err,
	fetch_word_if.assembler       fw
);
	import fetch_pkg::*;

	// Number of valid halfwords in {hwbuf, cir}
	level_t            buf_level;
	// Level once decode has consumed its halfwords
	level_t            level_left;
	level_t            fill_amount;
	level_t            level_next;
	// Spare halfword above the CIR
	hw_t               hwbuf;
	// Error flag per halfword of {hwbuf, cir}
	logic [2:0]        buf_err;
	logic [2:0]        err_shifted;
	logic [2:0]        err_merged;
	logic [3*W_HW-1:0] data_shifted;
	logic [3*W_HW-1:0] data_merged;
	word_t             fetch_aligned;

	// ------------------------------------------------------------
	// Consumption

	// Move leftover halfwords down over what decode used
	// Slots that end up invalid or overwritten take whatever is cheapest
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[W_DATA-1:W_HW], hwbuf};
			err_shifted = buf_err >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir[W_DATA-1:W_HW]};
			err_shifted = buf_err >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted = buf_err;
		end
	end

	assign level_left = buf_level - cir_use;

	// ------------------------------------------------------------
	// Fetch overlay

	// Lower slot takes the upper halfword when the lower one is not wanted
	assign fetch_aligned = {
		fw.data[W_DATA-1:W_HW],
		fw.hwvld[0] ? fw.data[W_HW-1:0] : fw.data[W_DATA-1:W_HW]
	};

	// A full word needs two free slots and a half word needs one
	assign fw.room = level_left <= (&fw.hwvld ? 2'd1 : 2'd2);

	always_comb begin
		if (!fw.room) begin
			data_merged = data_shifted;
			err_merged = err_shifted;
		end else if (level_left[1]) begin
			// Only the spare slot is free
			data_merged = {fetch_aligned[W_HW-1:0], data_shifted[2*W_HW-1:0]};
			err_merged = {fw.err, err_shifted[1:0]};
		end else if (level_left[0]) begin
			data_merged = {fetch_aligned, data_shifted[W_HW-1:0]};
			err_merged = {{2{fw.err}}, err_shifted[0]};
		end else begin
			data_merged = {data_shifted[3*W_HW-1:2*W_HW], fetch_aligned};
			err_merged = {err_shifted[2], {2{fw.err}}};
		end
	end

	// Level only advances when a real word arrives
	assign fill_amount = (fw.room && fw.vld) ? (&fw.hwvld ? 2'd2 : 2'd1) : 2'd0;

	// A jump throws away everything held here
	assign level_next = jump_now ? 2'd0 : level_left + fill_amount;

	// ------------------------------------------------------------
	// Registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
			buf_err <= 3'b000;
		end else begin
			buf_level <= level_next;
			// CIR holds two halfwords, so a level of 3 shows as 2
			cir_vld <= level_next & ~(level_next >> 1);
			buf_err <= err_merged;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_merged;
	end

	assign cir_err = buf_err[1:0];

endmodule

`default_nettype wire

//--- rtl/prefetch_queue.sv
`timescale 1ns/1ns
`default_nettype none

module prefetch_queue #(
	parameter int QUEUE_DEPTH = 2
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire fetch_pkg::word_t    mem_data,
	input  wire                      mem_data_err,
	input  wire                      mem_data_vld,
	input  wire                      jump_now,
	input  wire                      discard,
	input  wire fetch_pkg::hw_mask_t resp_hwvld,
	output logic                     full,
	output logic                     almost_full,
	fetch_word_if.queue              fw
);
	import fetch_pkg::*;

	// Entry 0 is the oldest word, and valid entries are always packed from 0
	word_t            q_data [QUEUE_DEPTH];
	logic             q_err [QUEUE_DEPTH];
	hw_mask_t         q_hwvld [QUEUE_DEPTH];
	wire [QUEUE_DEPTH-1:0] q_vld;
	logic             empty;
	logic             push;
	logic             pop;

	assign empty = !q_vld[0];
	assign full = q_vld[QUEUE_DEPTH-1];
	assign almost_full = q_vld[QUEUE_DEPTH-2];

	// Bus data skips the queue when it is empty and the assembler has room
	assign push = mem_data_vld && !discard && !(fw.room && empty);
	assign pop = fw.room && !empty;

	// ------------------------------------------------------------
	// Bypass to the assembler

	assign fw.data = empty ? mem_data : q_data[0];
	assign fw.hwvld = empty ? resp_hwvld : q_hwvld[0];
	assign fw.err = empty ? mem_data_err : q_err[0];
	assign fw.vld = !empty || (mem_data_vld && !discard);

	// ------------------------------------------------------------
	// Queue entries

	for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_entry
		// Entry above this one, or the bus word past the top entry
		word_t    up_data;
		logic     up_err;
		hw_mask_t up_hwvld;
		logic     up_vld;
		// Entry below is valid, so a push may land here
		logic     below_vld;

		assign q_vld[i] = |q_hwvld[i];

		if (i == QUEUE_DEPTH - 1) begin : g_top
			assign up_vld = 1'b0;
			assign up_data = mem_data;
			assign up_err = mem_data_err;
			assign up_hwvld = 2'b00;
		end else begin : g_mid
			assign up_vld = q_vld[i+1];
			assign up_data = q_vld[i+1] ? q_data[i+1] : mem_data;
			assign up_err = q_vld[i+1] ? q_err[i+1] : mem_data_err;
			assign up_hwvld = q_hwvld[i+1];
		end

		if (i == 0) begin : g_bottom
			assign below_vld = 1'b1;
		end else begin : g_upper
			assign below_vld = q_vld[i-1];
		end

		// Word payload shifts down on a pop, or takes bus data on a push
		always_ff @(posedge clk) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= up_data;
				q_err[i] <= up_err;
			end
		end

		// The halfword mask doubles as the valid flag of the entry
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				q_hwvld[i] <= 2'b00;
			end else if (jump_now) begin
				q_hwvld[i] <= 2'b00;
			end else if (up_vld && pop) begin
				q_hwvld[i] <= up_hwvld;
			end else if (q_vld[i] && pop) begin
				// Top valid entry refills from the bus as the rest moves down
				q_hwvld[i] <= push ? resp_hwvld : 2'b00;
			end else if (!q_vld[i] && push && !pop && below_vld) begin
				q_hwvld[i] <= resp_hwvld;
			end
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

if ! verilator --binary --timing --timescale 1ns/1ns -Mdir "$BUILD_DIR" \
	--top-module tb_fetch_frontend -f fetch_frontend.f; then
	echo "Verilator build failed"
	exit 1
fi

OUTPUT=$("$BUILD_DIR/Vtb_fetch_frontend")
STATUS=$?
printf '%s\n' "$OUTPUT"

if [ "$STATUS" -ne 0 ]; then
	echo "Simulation exited with status $STATUS"
	exit 1
fi

if printf '%s\n' "$OUTPUT" | grep -q -F '*** TEST PASSED ***'; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- testbench/fetch_bus_model.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_bus_model #(
	parameter fetch_pkg::addr_t RESET_VECTOR = '0,
	parameter fetch_pkg::addr_t ERR_LO       = '0,
	parameter fetch_pkg::addr_t ERR_HI       = '0,
	parameter int               RDY_PCT      = 60
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire fetch_pkg::addr_t mem_addr,
	input  wire                   mem_addr_vld,
	output logic                  mem_addr_rdy,
	output fetch_pkg::word_t      mem_data,
	output logic                  mem_data_err,
	output logic                  mem_data_vld,
	output fetch_pkg::addr_t      word_addr,
	input  wire fetch_pkg::word_t word_data,
	output int                    error_count
);
	import fetch_pkg::*;

	// Address accepted at the coming edge, so its data goes out one cycle later
	logic  accepted;
	logic  held;
	logic  first_done;
	logic  out_of_reset;
	addr_t held_addr;
	int    outstanding;

	initial begin
		mem_addr_rdy = 1'b0;
		mem_data = '0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		word_addr = '0;
		error_count = 0;
		accepted = 1'b0;
		held = 1'b0;
		first_done = 1'b0;
		out_of_reset = 1'b0;
		held_addr = '0;
		outstanding = 0;
		forever begin
			@(negedge clk);
			// ------------------------------------------------------------
			// Data phase of the word accepted at the last edge
			mem_data_vld = accepted;
			if (accepted) begin
				mem_data = word_data;
				mem_data_err = (word_addr >= ERR_LO) && (word_addr <= ERR_HI);
			end
			mem_addr_rdy = ($urandom % 100) < RDY_PCT;
			// Let the DUT settle on this cycle's inputs before sampling
			#1;
			if (rst_n && !out_of_reset && !mem_addr_vld) begin
				$display("[FAIL] %0t mem_addr_vld: expected 1, got 0", $time);
				error_count++;
			end
			out_of_reset = rst_n;
			// A held address phase must come back unchanged
			if (held && (!mem_addr_vld || mem_addr !== held_addr)) begin
				$display("[FAIL] %0t mem_addr: expected %h, got %h (vld %b)",
					$time, held_addr, mem_addr, mem_addr_vld);
				error_count++;
			end
			held = rst_n && mem_addr_vld && !mem_addr_rdy;
			held_addr = mem_addr;
			accepted = rst_n && mem_addr_vld && mem_addr_rdy;
			if (accepted) begin
				word_addr = mem_addr;
				if (!first_done && mem_addr !== RESET_VECTOR) begin
					$display("[FAIL] %0t mem_addr: expected %h, got %h",
						$time, RESET_VECTOR, mem_addr);
					error_count++;
				end
				first_done = 1'b1;
				outstanding++;
			end
			if (mem_data_vld) outstanding--;
			if (outstanding > 2) begin
				$display("Bus model saw %0d fetches outstanding at %0t, more than two",
					outstanding, $time);
				error_count++;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_fetch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_frontend;
	import fetch_pkg::*;

	localparam addr_t RESET_VECTOR = 32'h0000_0100;
	localparam int    QUEUE_DEPTH  = 2;
	// Words in this window come back with a bus error
	localparam addr_t ERR_LO = 32'h0000_0140;
	localparam addr_t ERR_HI = 32'h0000_015f;

	logic     clk;
	logic     rst_n;
	logic     mem_addr_rdy;
	word_t    mem_data;
	logic     mem_data_err;
	logic     mem_data_vld;
	addr_t    jump_target;
	logic     jump_target_vld;
	level_t   cir_use;
	addr_t    mem_addr;
	logic     mem_addr_vld;
	logic     jump_target_rdy;
	word_t    cir;
	level_t   cir_vld;
	hw_mask_t cir_err;
	addr_t    model_addr;
	word_t    model_word;
	int       model_errors;

	// Shared between the sequence, the decode model and the checker
	int    use_pct;
	addr_t jump_dest;
	int    jump_req;
	int    jumps_taken;
	int    consumed;
	int    check_errors;
	int    timeouts;
	int    straddles;
	int    err_hits;
	addr_t pc;
	logic  jump_last;

	// Program image: a hash per halfword, with chosen slots marked as 32-bit starts
	function automatic hw_t hw_at(input addr_t a);
		logic [31:0] h;
		hw_t hw;
		h = a * 32'h9e37_79b1;
		h = h ^ (h >> 16);
		h = h * 32'h85eb_ca6b;
		h = h ^ (h >> 13);
		hw = h[15:0];
		if (a[3:1] == 3'd1 || a[3:1] == 3'd3 || a[3:1] == 3'd6) begin
			hw[1:0] = 2'b11;
		end else begin
			hw[0] = 1'b0;
		end
		return hw;
	endfunction

	function automatic logic in_err_window(input addr_t a);
		return (a >= ERR_LO) && (a <= ERR_HI);
	endfunction

	assign model_word = {hw_at(model_addr + 32'd2), hw_at(model_addr)};

	fetch_frontend #(
		.RESET_VECTOR (RESET_VECTOR),
		.QUEUE_DEPTH  (QUEUE_DEPTH)
	) fetch_frontend_inst (
		.clk (clk), .rst_n (rst_n), .mem_addr_rdy (mem_addr_rdy), .mem_data (mem_data),
		.mem_data_err (mem_data_err), .mem_data_vld (mem_data_vld),
		.jump_target (jump_target), .jump_target_vld (jump_target_vld), .cir_use (cir_use),
		.mem_addr (mem_addr), .mem_addr_vld (mem_addr_vld),
		.jump_target_rdy (jump_target_rdy), .cir (cir), .cir_vld (cir_vld), .cir_err (cir_err)
	);

	fetch_bus_model #(
		.RESET_VECTOR (RESET_VECTOR), .ERR_LO (ERR_LO), .ERR_HI (ERR_HI)
	) fetch_bus_model_inst (
		.clk (clk), .rst_n (rst_n), .mem_addr (mem_addr), .mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy), .mem_data (mem_data), .mem_data_err (mem_data_err),
		.mem_data_vld (mem_data_vld), .word_addr (model_addr), .word_data (model_word),
		.error_count (model_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------
	// Decode model, consumes whole instructions when the draw allows
	initial begin
		level_t len;
		jump_target = '0;
		jump_target_vld = 1'b0;
		cir_use = 2'd0;
		forever begin
			@(negedge clk);
			jump_target_vld = (jump_req != jumps_taken);
			jump_target = jump_dest;
			len = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
			if (!jump_target_vld && cir_vld >= len && ($urandom % 100) < use_pct) begin
				cir_use = len;
			end else begin
				cir_use = 2'd0;
			end
		end
	end

	task automatic check_halfword(input logic slot, input addr_t a);
		hw_t  got_hw;
		logic got_err;
		got_hw = slot ? cir[31:16] : cir[15:0];
		got_err = slot ? cir_err[1] : cir_err[0];
		if (got_hw !== hw_at(a)) begin
			$display("[FAIL] %0t cir[%0d:%0d]: expected %h, got %h",
				$time, slot ? 31 : 15, slot ? 16 : 0, hw_at(a), got_hw);
			check_errors++;
		end
		if (got_err !== in_err_window(a)) begin
			$display("[FAIL] %0t cir_err[%0d]: expected %b, got %b",
				$time, slot, in_err_window(a), got_err);
			check_errors++;
		end
		if (in_err_window(a)) err_hits++;
	endtask

	// ------------------------------------------------------------
	// Checker walks the expected PC through the program image
	initial begin
		// An address phase left waiting at the last edge, which blocks jumps
		logic addr_held;
		pc = RESET_VECTOR;
		consumed = 0;
		jumps_taken = 0;
		check_errors = 0;
		straddles = 0;
		err_hits = 0;
		jump_last = 1'b0;
		addr_held = 1'b0;
		forever begin
			@(negedge clk);
			#2;
			if (cir_vld !== 2'd0 && (!rst_n || jump_last)) begin
				$display("[FAIL] %0t cir_vld: expected 0, got %0d", $time, cir_vld);
				check_errors++;
			end
			jump_last = 1'b0;
			if (rst_n && jump_target_rdy !== !addr_held) begin
				$display("[FAIL] %0t jump_target_rdy: expected %b, got %b",
					$time, !addr_held, jump_target_rdy);
				check_errors++;
			end
			addr_held = rst_n && mem_addr_vld && !mem_addr_rdy;
			if (rst_n && cir_use != 2'd0) begin
				check_halfword(1'b0, pc);
				if (cir_use == 2'd2) begin
					check_halfword(1'b1, pc + 32'd2);
					// Odd halfword start means the instruction spans two words
					if (pc[1]) straddles++;
				end
				pc = pc + {29'd0, cir_use, 1'b0};
				consumed++;
			end
			if (rst_n && jump_target_vld && jump_target_rdy) begin
				pc = {jump_target[W_ADDR-1:1], 1'b0};
				jumps_taken++;
				jump_last = 1'b1;
			end
		end
	end

	task automatic wait_consumed(input int count);
		int target;
		int waited;
		target = consumed + count;
		waited = 0;
		while (timeouts == 0 && consumed < target && waited < 60 * count + 200) begin
			@(posedge clk);
			waited++;
		end
		if (timeouts == 0 && consumed < target) begin
			$display("Timeout at %0t: decode took %0d of %0d instructions",
				$time, count - (target - consumed), count);
			timeouts++;
		end
	endtask

	task automatic jump_to(input addr_t target);
		int waited;
		waited = 0;
		if (timeouts == 0) begin
			jump_dest = target;
			jump_req = jump_req + 1;
			while (jumps_taken != jump_req && waited < 100) begin
				@(posedge clk);
				waited++;
			end
			if (jumps_taken != jump_req) begin
				$display("Timeout at %0t: jump to %h was never accepted", $time, target);
				timeouts++;
			end
			wait_consumed(16);
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	initial begin
		int misses;
		void'($urandom(32'hce495358));
		rst_n = 1'b0;
		use_pct = 100;
		jump_dest = '0;
		jump_req = 0;
		timeouts = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Straight-line fetch through the error window, then decode stalls
		wait_consumed(120);
		use_pct = 35;
		wait_consumed(120);
		// Even target, odd target, odd target inside the error window
		jump_to(32'h0000_1000);
		jump_to(32'h0000_2002);
		jump_to(32'h0000_014a);
		use_pct = 100;
		jump_to(32'h0000_3006);
		use_pct = 50;
		for (int i = 0; i < 8; i++) begin
			jump_to(addr_t'($urandom) & 32'h0000_fffe);
		end
		misses = 0;
		if (straddles == 0 || err_hits == 0) begin
			$display("Stimulus missed straddling instructions or the error window");
			misses = 1;
		end
		$display("Done: %0d instr, %0d jumps, %0d check err, %0d bus err, %0d timeouts, %0d misses",
			consumed, jumps_taken, check_errors, model_errors, timeouts, misses);
		if (check_errors == 0 && model_errors == 0 && timeouts == 0 && misses == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
